//--- tb.f
hw/rob_rd_pkg.sv
hw/rd_slot_counter.sv
hw/rd_rob_store.sv
hw/rd_order_fsm.sv
hw/rob_rd_shim.sv
test/rob_rd_shim_asserts.sv
test/tb_rob_rd_shim.sv

//--- test/tb_rob_rd_shim.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob_rd_shim;

    localparam int N_ENTRIES      = 16;
    localparam int ALM_FULL_SLACK = 2;

    // Requests over all tests where each one is given about 60 cycles to complete
    localparam int N_REQ          = 8 + 12 + 10 + 2;
    localparam int TIMEOUT_CYCLES = N_REQ * 60 + 200;

    // Host read data is the address plus a per-beat stride, then scrambled
    localparam logic [63:0] LINE_STRIDE  = 64'h0000_0001_0000_0040;
    localparam logic [63:0] LINE_PATTERN = 64'hA5A5_5A5A_0F0F_F0F0;

    logic                clk;
    logic                reset_n;
    rob_rd_pkg::t_rd_req afu_req;
    rob_rd_pkg::t_c0_rsp afu_rsp;
    logic                alm_full;
    rob_rd_pkg::t_rd_req fiu_req;
    rob_rd_pkg::t_c0_rsp fiu_rsp;
    logic                fiu_alm_full;

    integer seed = 12;
    int     cycle = 0;
    int     check_cnt = 0;
    int     err_cnt = 0;
    int     tag_err_cnt = 0;
    int     errs_at_start;
    int     assert_fails;

    // Expected read beats in request order, and pass-through responses with their due cycle
    rob_rd_pkg::t_c0_rsp exp_rd_q [$];
    rob_rd_pkg::t_c0_rsp pass_exp_q [$];
    int                  pass_due_q [$];
    rob_rd_pkg::t_c0_rsp exp_item;

    // Host model state with one entry per beat not yet returned
    logic [rob_rd_pkg::MDATA_W-1:0]  pend_tag [$];
    logic [rob_rd_pkg::CL_NUM_W-1:0] pend_beat [$];
    logic [rob_rd_pkg::ADDR_W-1:0]   pend_addr [$];
    logic                            host_enable;
    logic                            host_shuffle;
    logic                            inject_req;
    rob_rd_pkg::t_c0_rsp             inject_rsp;
    int                              pick;

    // Model of the rotating allocation pointer and of the slots in use
    int   tag_ptr = 0;
    int   free_ptr = 0;
    int   slot;
    logic slot_busy [N_ENTRIES];

    rob_rd_shim
    #(
        .N_ENTRIES      (N_ENTRIES),
        .ALM_FULL_SLACK (ALM_FULL_SLACK)
    )
    DUT
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .afu_req      (afu_req),
        .afu_rsp      (afu_rsp),
        .alm_full     (alm_full),
        .fiu_req      (fiu_req),
        .fiu_rsp      (fiu_rsp),
        .fiu_alm_full (fiu_alm_full)
    );

    always #4 clk = ~clk;

    // ========================================
    // Reference functions
    // ========================================

    function automatic logic [rob_rd_pkg::DATA_W-1:0] expected_line(
        input logic [rob_rd_pkg::ADDR_W-1:0] addr,
        input int                            beat
    );
        return ({32'h0, addr} + 64'(beat) * LINE_STRIDE) ^ LINE_PATTERN;
    endfunction

    // Almost-full is due once fewer than (slack+1) bursts of slots remain free
    function automatic logic expected_alm_full(input int outstanding, input logic host_full);
        return host_full ||
               (outstanding > N_ENTRIES - (ALM_FULL_SLACK + 1) * rob_rd_pkg::MAX_BEATS);
    endfunction

    // ========================================
    // Compare and report tasks
    // ========================================

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_rd_rsp(input rob_rd_pkg::t_c0_rsp got, input rob_rd_pkg::t_c0_rsp exp);
        check_cnt++;
        if (got.mdata !== exp.mdata)
        begin
            $display("mismatch at %0t: afu_rsp.mdata got %h expected %h", $time, got.mdata,
                     exp.mdata);
            err_cnt++;
        end
        if (got.cl_num !== exp.cl_num)
        begin
            $display("mismatch at %0t: afu_rsp.cl_num got %0d expected %0d", $time, got.cl_num,
                     exp.cl_num);
            err_cnt++;
        end
        if (got.data !== exp.data)
        begin
            $display("mismatch at %0t: afu_rsp.data got %h expected %h", $time, got.data,
                     exp.data);
            err_cnt++;
        end
    endtask

    task automatic check_pass_rsp(input rob_rd_pkg::t_c0_rsp got, input rob_rd_pkg::t_c0_rsp exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: afu_rsp got %h expected %h", $time, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(
        input logic [rob_rd_pkg::MDATA_W-1:0] got,
        input logic [rob_rd_pkg::MDATA_W-1:0] exp
    );
        check_cnt++;
        if (got !== exp)
        begin
            $display("mismatch at %0t: fiu_req.mdata got %h expected %h", $time, got, exp);
            err_cnt++;
            tag_err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int n_errs);
        if (n_errs == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, n_errs);
    endtask

    // ========================================
    // Stimulus tasks
    // ========================================

    // Waits out almost-full, issues one request and queues its beats as expected results
    task automatic send_read(
        input logic [rob_rd_pkg::ADDR_W-1:0]   addr,
        input logic [rob_rd_pkg::CL_NUM_W-1:0] len,
        input logic [rob_rd_pkg::MDATA_W-1:0]  tag
    );
        rob_rd_pkg::t_c0_rsp e;
        @(negedge clk);
        while (alm_full)
            @(negedge clk);
        @(posedge clk);
        #1;
        afu_req.valid  = 1'b1;
        afu_req.addr   = addr;
        afu_req.cl_len = len;
        afu_req.mdata  = tag;
        for (int b = 0; b <= len; b++)
        begin
            e          = '0;
            e.valid    = 1'b1;
            e.rsp_type = rob_rd_pkg::RSP_RDLINE;
            e.mdata    = tag;
            e.cl_num   = rob_rd_pkg::CL_NUM_W'(b);
            e.data     = expected_line(addr, b);
            exp_rd_q.push_back(e);
        end
        @(posedge clk);
        #1;
        afu_req = '0;
    endtask

    // Hands a non-read response to the host model, which puts it on the bus next cycle
    task automatic inject_nonrd(input rob_rd_pkg::t_rsp_type kind);
        @(negedge clk);
        inject_rsp.valid    = 1'b1;
        inject_rsp.rsp_type = kind;
        inject_rsp.mdata    = $random(seed);
        inject_rsp.cl_num   = $random(seed);
        inject_rsp.error    = $random(seed);
        inject_rsp.data     = {$random(seed), $random(seed)};
        inject_req          = 1'b1;
        while (inject_req)
            @(negedge clk);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (exp_rd_q.size() != 0 || pend_tag.size() != 0 || pass_due_q.size() != 0)
            @(negedge clk);
    endtask

    // ========================================
    // Host model
    // ========================================

    // Drives fiu_rsp just after each edge with at most one beat per cycle
    always @(posedge clk)
    begin
        #1;
        fiu_rsp = '0;
        if (reset_n && inject_req)
        begin
            fiu_rsp = inject_rsp;
            pass_exp_q.push_back(inject_rsp);
            pass_due_q.push_back(cycle + 2);
            inject_req = 1'b0;
        end
        else if (reset_n && host_enable && pend_tag.size() != 0)
        begin
            // In shuffle mode a random pending beat goes out about two cycles in three
            if (!host_shuffle || ($unsigned($random(seed)) % 3 != 0))
            begin
                pick = host_shuffle ? int'($unsigned($random(seed)) % pend_tag.size()) : 0;
                fiu_rsp.valid    = 1'b1;
                fiu_rsp.rsp_type = rob_rd_pkg::RSP_RDLINE;
                fiu_rsp.mdata    = pend_tag[pick];
                fiu_rsp.cl_num   = pend_beat[pick];
                fiu_rsp.data     = expected_line(pend_addr[pick], pend_beat[pick]);
                pend_tag.delete(pick);
                pend_beat.delete(pick);
                pend_addr.delete(pick);
            end
        end
    end

    // ========================================
    // Monitor and compare
    // ========================================

    // All DUT outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (pass_due_q.size() != 0 && pass_due_q[0] == cycle)
            begin
                exp_item = pass_exp_q.pop_front();
                void'(pass_due_q.pop_front());
                check_pass_rsp(afu_rsp, exp_item);
            end
            else if (afu_rsp.valid && afu_rsp.rsp_type != rob_rd_pkg::RSP_RDLINE)
            begin
                report_error("non-read response on afu_rsp that was never injected");
            end
            else if (afu_rsp.valid && exp_rd_q.size() == 0)
            begin
                report_error("read beat delivered with no read outstanding");
            end
            else if (afu_rsp.valid)
            begin
                exp_item = exp_rd_q.pop_front();
                check_rd_rsp(afu_rsp, exp_item);
                slot_busy[free_ptr] = 1'b0;
                free_ptr = (free_ptr + 1) % N_ENTRIES;
            end

            // Each host tag must be the previous base plus the previous length
            if (fiu_req.valid)
            begin
                check_tag(fiu_req.mdata, rob_rd_pkg::MDATA_W'(tag_ptr));
                for (int b = 0; b <= fiu_req.cl_len; b++)
                begin
                    slot = (int'(fiu_req.mdata) + b) % N_ENTRIES;
                    if (slot_busy[slot])
                    begin
                        report_error($sformatf("slot %0d handed out again while still in use",
                                               slot));
                        tag_err_cnt++;
                    end
                    slot_busy[slot] = 1'b1;
                    pend_tag.push_back(fiu_req.mdata);
                    pend_beat.push_back(rob_rd_pkg::CL_NUM_W'(b));
                    pend_addr.push_back(fiu_req.addr);
                end
                // The pointer model advances by the length the accelerator asked for
                tag_ptr = (tag_ptr + int'(afu_req.cl_len) + 1) % N_ENTRIES;
            end
        end
    end

    // Cycle count for pass-through timing and the run limit
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES)
        begin
            $display("timeout: responses still outstanding after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        afu_req      = '0;
        fiu_rsp      = '0;
        fiu_alm_full = 1'b0;
        host_enable  = 1'b1;
        host_shuffle = 1'b0;
        inject_req   = 1'b0;
        inject_rsp   = '0;
        for (int i = 0; i < N_ENTRIES; i++)
            slot_busy[i] = 1'b0;

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Outputs are quiet straight out of reset
        errs_at_start = err_cnt;
        @(negedge clk);
        check_flag("afu_rsp.valid", afu_rsp.valid, 1'b0);
        check_flag("alm_full", alm_full, expected_alm_full(0, fiu_alm_full));
        report_test("reset state", err_cnt - errs_at_start);

        // Single lines that the host answers in order
        errs_at_start = err_cnt;
        for (int i = 0; i < 8; i++)
            send_read($random(seed), 2'd0, $random(seed));
        wait_idle();
        report_test("single-line in order", err_cnt - errs_at_start);

        // Bursts of 2 to 4 lines with beats shuffled across requests
        errs_at_start = err_cnt;
        host_shuffle = 1'b1;
        for (int i = 0; i < 12; i++)
            send_read($random(seed), 2'd1 + ($unsigned($random(seed)) % 3), $random(seed));
        wait_idle();
        report_test("multi-line shuffled", err_cnt - errs_at_start);
        report_test("rotating host tags", tag_err_cnt);

        // Write and other responses mixed into shuffled read traffic
        errs_at_start = err_cnt;
        for (int i = 0; i < 10; i++)
        begin
            send_read($random(seed), $random(seed), $random(seed));
            inject_nonrd(i % 2 ? rob_rd_pkg::RSP_WRLINE : rob_rd_pkg::RSP_OTHER);
        end
        wait_idle();
        report_test("pass-through amid reads", err_cnt - errs_at_start);

        // Host paused so the outstanding beat count is known exactly
        errs_at_start = err_cnt;
        host_enable = 1'b0;
        send_read(32'h0000_1000, 2'd3, 16'h5A00);
        @(negedge clk);
        check_flag("alm_full", alm_full, expected_alm_full(4, fiu_alm_full));
        send_read(32'h0000_2000, 2'd0, 16'h5A01);
        @(negedge clk);
        check_flag("alm_full", alm_full, expected_alm_full(5, fiu_alm_full));
        host_enable = 1'b1;
        wait_idle();
        check_flag("alm_full", alm_full, expected_alm_full(0, fiu_alm_full));
        @(posedge clk);
        #1;
        fiu_alm_full = 1'b1;
        @(negedge clk);
        check_flag("alm_full", alm_full, expected_alm_full(0, fiu_alm_full));
        @(posedge clk);
        #1;
        fiu_alm_full = 1'b0;
        @(negedge clk);
        check_flag("alm_full", alm_full, expected_alm_full(0, fiu_alm_full));
        report_test("almost-full", err_cnt - errs_at_start);

        repeat (4) @(negedge clk);
        assert_fails = DUT.u_asserts.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
                 assert_fails);
        if (err_cnt == 0 && assert_fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/rob_rd_shim_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol properties of the reorder shim that are bound into every instance of its top level
module rob_rd_shim_asserts
(
    input logic                clk,
    input logic                reset_n,
    input rob_rd_pkg::t_c0_rsp afu_rsp,
    input logic                deq_en,

    // Packet FSM state where SOP is encoded as zero
    input logic                fsm_state
);

    // Failures seen so far that the testbench reads at the end of the run
    int fail_cnt = 0;

    // A packet's first beat can only be delivered while the FSM waits for one
    first_beat_at_sop: assert property (@(posedge clk) disable iff (!reset_n)
        (afu_rsp.valid && afu_rsp.rsp_type == rob_rd_pkg::RSP_RDLINE && afu_rsp.cl_num == '0)
        |-> (fsm_state == 1'b0))
    else
    begin
        $error("first beat of a packet delivered while the FSM was mid-packet");
        fail_cnt++;
    end

    // Every dequeue puts its read beat on the accelerator side exactly two cycles later
    deq_beat_two_cycles: assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> ##2 (afu_rsp.valid && afu_rsp.rsp_type == rob_rd_pkg::RSP_RDLINE))
    else
    begin
        $error("no read beat on the accelerator side two cycles after a dequeue");
        fail_cnt++;
    end

    // Registers clear on the first reset edge, so the next cycle must be quiet
    quiet_in_reset: assert property (@(posedge clk) !reset_n |=> !afu_rsp.valid)
    else
    begin
        $error("response valid on the accelerator side during reset");
        fail_cnt++;
    end

endmodule

bind rob_rd_shim rob_rd_shim_asserts u_asserts
(
    .clk       (clk),
    .reset_n   (reset_n),
    .afu_rsp   (afu_rsp),
    .deq_en    (deq_en),
    .fsm_state (u_order_fsm.state)
);

`default_nettype wire

//--- hw/rob_rd_shim.sv
`timescale 1ns/1ps
`default_nettype none

// Read-response reordering shim between the accelerator and the host port
// Requests leave with a ROB index as their tag, and responses come back to
// the accelerator in request order with the original tag restored
module rob_rd_shim
#(
    parameter int N_ENTRIES      = 16,
    parameter int ALM_FULL_SLACK = 2
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Accelerator side
    input  rob_rd_pkg::t_rd_req  afu_req,
    output rob_rd_pkg::t_c0_rsp  afu_rsp,
    output logic                 alm_full,

    // Host side
    output rob_rd_pkg::t_rd_req  fiu_req,
    input  rob_rd_pkg::t_c0_rsp  fiu_rsp,
    input  logic                 fiu_alm_full
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    // Allocation
    logic                          alloc_en;
    logic [rob_rd_pkg::CL_NUM_W:0] alloc_cnt;
    logic [IDX_W-1:0]              alloc_idx;
    logic                          not_full;

    // Dequeue and head data
    logic                            deq_en;
    logic                            not_empty;
    rob_rd_pkg::t_c0_rsp             head_rsp;
    logic [rob_rd_pkg::CL_NUM_W-1:0] head_len;

    // Host response after one register
    rob_rd_pkg::t_c0_rsp fiu_rsp_q;

    // ========================================
    // Request path
    // ========================================

    // Every valid request on this channel is a read of cl_len+1 lines
    always_comb
    begin
        alloc_en  = afu_req.valid;
        alloc_cnt = {1'b0, afu_req.cl_len} + (rob_rd_pkg::CL_NUM_W + 1)'(1);
    end

    // The tag toward the host is the zero-extended base index
    always_comb
    begin
        fiu_req                  = afu_req;
        fiu_req.mdata            = '0;
        fiu_req.mdata[IDX_W-1:0] = alloc_idx;
    end

    // Almost-full comes from the host or from a ROB short of slots
    assign alm_full = fiu_alm_full || !not_full;

    // ========================================
    // Response input register
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fiu_rsp_q.valid <= 1'b0;
        end
        else
        begin
            fiu_rsp_q <= fiu_rsp;
        end
    end

    rd_slot_counter
    #(
        .N_ENTRIES      (N_ENTRIES),
        .ALM_FULL_SLACK (ALM_FULL_SLACK)
    )
    u_slot_counter
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc_en  (alloc_en),
        .alloc_cnt (alloc_cnt),
        .free_en   (deq_en),
        .alloc_idx (alloc_idx),
        .not_full  (not_full)
    );

    rd_rob_store
    #(
        .N_ENTRIES (N_ENTRIES)
    )
    u_rob_store
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc_en  (alloc_en),
        .alloc_idx (alloc_idx),
        .alloc_req (afu_req),
        .rsp_in    (fiu_rsp_q),
        .deq_en    (deq_en),
        .not_empty (not_empty),
        .head_rsp  (head_rsp),
        .head_len  (head_len)
    );

    // Sees the raw host response so it can yield to non-read traffic
    rd_order_fsm u_order_fsm
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fiu_rsp   (fiu_rsp),
        .not_empty (not_empty),
        .head_rsp  (head_rsp),
        .head_len  (head_len),
        .deq_en    (deq_en),
        .afu_rsp   (afu_rsp)
    );

endmodule

`default_nettype wire

//--- hw/rd_order_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// Packet tracking and output merge for the response channel
// Decides when the ROB may dequeue, restores the user tag on every beat of
// a packet and merges sorted read beats with pass-through responses
module rd_order_fsm
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Raw host response, before any register
    input  rob_rd_pkg::t_c0_rsp               fiu_rsp,

    // ROB head state and two-cycle read data
    input  logic                              not_empty,
    input  rob_rd_pkg::t_c0_rsp               head_rsp,
    input  logic [rob_rd_pkg::CL_NUM_W-1:0]   head_len,

    output logic                              deq_en,
    output rob_rd_pkg::t_c0_rsp               afu_rsp
);

    // SOP means the next delivered beat starts a packet
    typedef enum logic {
        SOP,
        MID_PACKET
    } t_state;

    t_state state;

    // Non-read response present on the host side this cycle
    logic non_rd_valid;

    // Dequeue pipeline, data_rdy lines up with head_rsp
    logic deq_q;
    logic data_rdy;

    // Pass-through delay line
    rob_rd_pkg::t_c0_rsp pass_q;
    rob_rd_pkg::t_c0_rsp pass_qq;

    // Tag and length held from the first beat of a packet
    logic [rob_rd_pkg::MDATA_W-1:0]  held_mdata;
    logic [rob_rd_pkg::CL_NUM_W-1:0] held_len;

    logic [rob_rd_pkg::MDATA_W-1:0]  cur_mdata;
    logic [rob_rd_pkg::CL_NUM_W-1:0] cur_len;
    logic                            eop;

    // ========================================
    // Dequeue decision
    // ========================================

    // A non-read response claims the output slot two cycles from now, so the
    // ROB holds off for this one cycle and the two never collide
    always_comb
    begin
        non_rd_valid = fiu_rsp.valid && (fiu_rsp.rsp_type != rob_rd_pkg::RSP_RDLINE);
        deq_en       = not_empty && !non_rd_valid;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            deq_q    <= 1'b0;
            data_rdy <= 1'b0;
        end
        else
        begin
            deq_q    <= deq_en;
            data_rdy <= deq_q;
        end
    end

    // ========================================
    // Pass-through path
    // ========================================

    // Raw read responses are dropped here since their data comes via the ROB
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pass_q.valid  <= 1'b0;
            pass_qq.valid <= 1'b0;
        end
        else
        begin
            pass_q       <= fiu_rsp;
            pass_q.valid <= non_rd_valid;
            pass_qq      <= pass_q;
        end
    end

    // ========================================
    // Packet tracking
    // ========================================

    // The first beat carries its own metadata, later beats reuse the held copy
    always_comb
    begin
        if (state == SOP)
        begin
            cur_mdata = head_rsp.mdata;
            cur_len   = head_len;
        end
        else
        begin
            cur_mdata = held_mdata;
            cur_len   = held_len;
        end

        eop = (head_rsp.cl_num == cur_len);
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= SOP;
        end
        else if (data_rdy)
        begin
            state <= eop ? SOP : MID_PACKET;
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_rdy && (state == SOP))
        begin
            held_mdata <= head_rsp.mdata;
            held_len   <= head_len;
        end
    end

    // ========================================
    // Output merge
    // ========================================

    always_comb
    begin
        afu_rsp = pass_qq;

        // A ROB beat rebuilds the header with the restored user tag
        if (data_rdy)
        begin
            afu_rsp          = head_rsp;
            afu_rsp.valid    = 1'b1;
            afu_rsp.rsp_type = rob_rd_pkg::RSP_RDLINE;
            afu_rsp.mdata    = cur_mdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/rd_rob_store.sv
`timescale 1ns/1ps
`default_nettype none

// Reorder storage for read beats
// Metadata is written at allocation into the packet's base entry, beats
// are written by host responses into base+cl_num, and the head pointer
// walks the entries strictly in allocation order
module rd_rob_store
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic                               clk,
    input  logic                               reset_n,

    // Allocation, same cycle as the request leaves for the host
    input  logic                               alloc_en,
    input  logic [$clog2(N_ENTRIES)-1:0]       alloc_idx,
    input  rob_rd_pkg::t_rd_req                alloc_req,

    // Registered host response
    input  rob_rd_pkg::t_c0_rsp                rsp_in,

    // Dequeue strobe and head state
    input  logic                               deq_en,
    output logic                               not_empty,
    output rob_rd_pkg::t_c0_rsp                head_rsp,
    output logic [rob_rd_pkg::CL_NUM_W-1:0]    head_len
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    // Metadata, meaningful only at the first entry of a packet
    logic [rob_rd_pkg::MDATA_W-1:0]  meta_mdata  [N_ENTRIES];
    logic [rob_rd_pkg::CL_NUM_W-1:0] meta_len    [N_ENTRIES];

    // Beat payload as returned by the host
    logic [rob_rd_pkg::DATA_W-1:0]   beat_data   [N_ENTRIES];
    logic                            beat_error  [N_ENTRIES];
    logic [rob_rd_pkg::CL_NUM_W-1:0] beat_cl_num [N_ENTRIES];

    // One bit per entry, set when the beat lands and cleared on dequeue
    logic [N_ENTRIES-1:0] entry_valid;
    logic [IDX_W-1:0]     head;

    // Beat write decode
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;

    // Two read stages between the dequeue and the data
    rob_rd_pkg::t_c0_rsp             rd_s1;
    rob_rd_pkg::t_c0_rsp             rd_s2;
    logic [rob_rd_pkg::CL_NUM_W-1:0] len_s1;
    logic [rob_rd_pkg::CL_NUM_W-1:0] len_s2;

    // ========================================
    // Write side
    // ========================================

    // The host echoes the base index in mdata, so the beat's own slot is
    // that base plus its line number
    always_comb
    begin
        wr_en  = rsp_in.valid && (rsp_in.rsp_type == rob_rd_pkg::RSP_RDLINE);
        wr_idx = rsp_in.mdata[IDX_W-1:0] + IDX_W'(rsp_in.cl_num);
    end

    always_ff @(posedge clk)
    begin
        if (alloc_en)
        begin
            meta_mdata[alloc_idx] <= alloc_req.mdata;
            meta_len[alloc_idx]   <= alloc_req.cl_len;
        end

        if (wr_en)
        begin
            beat_data[wr_idx]   <= rsp_in.data;
            beat_error[wr_idx]  <= rsp_in.error;
            beat_cl_num[wr_idx] <= rsp_in.cl_num;
        end
    end

    // ========================================
    // Valid bits and head pointer
    // ========================================

    // An entry being dequeued can never be written in the same cycle, since
    // its beat has already arrived and the slot is not reallocated yet
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            entry_valid <= '0;
            head        <= '0;
        end
        else
        begin
            if (deq_en)
            begin
                entry_valid[head] <= 1'b0;
                head              <= head + IDX_W'(1);
            end

            if (wr_en)
            begin
                entry_valid[wr_idx] <= 1'b1;
            end
        end
    end

    // Order is kept by looking only at the head entry
    assign not_empty = entry_valid[head];

    // ========================================
    // Two-cycle read path
    // ========================================

    // Stage one captures the head while it still points at the dequeued entry
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            rd_s1.valid    <= 1'b1;
            rd_s1.rsp_type <= rob_rd_pkg::RSP_RDLINE;
            rd_s1.mdata    <= meta_mdata[head];
            rd_s1.cl_num   <= beat_cl_num[head];
            rd_s1.error    <= beat_error[head];
            rd_s1.data     <= beat_data[head];
            len_s1         <= meta_len[head];
        end
    end

    // Stage two shifts every cycle so back-to-back dequeues stay in step
    always_ff @(posedge clk)
    begin
        rd_s2  <= rd_s1;
        len_s2 <= len_s1;
    end

    // Qualified downstream by the two-cycle delayed dequeue strobe
    assign head_rsp = rd_s2;
    assign head_len = len_s2;

endmodule

`default_nettype wire

//--- hw/rd_slot_counter.sv
`timescale 1ns/1ps
`default_nettype none

// Hands out ROB slots to read requests
// Every request takes cl_len+1 consecutive slots starting at the current
// pointer, and every dequeued beat gives exactly one slot back
module rd_slot_counter
#(
    parameter int N_ENTRIES      = 16,
    parameter int ALM_FULL_SLACK = 2
)
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Allocation side, driven by the accelerator request
    input  logic                              alloc_en,
    input  logic [rob_rd_pkg::CL_NUM_W:0]     alloc_cnt,

    // One slot returns per dequeue
    input  logic                              free_en,

    output logic [$clog2(N_ENTRIES)-1:0]      alloc_idx,
    output logic                              not_full
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    // The free count must be able to hold N_ENTRIES itself
    localparam int CNT_W = IDX_W + 1;

    // Room for the request in flight plus ALM_FULL_SLACK more worst-case bursts
    // that may still arrive after almost-full is raised
    localparam int MIN_FREE = (ALM_FULL_SLACK + 1) * rob_rd_pkg::MAX_BEATS;

    logic [IDX_W-1:0] alloc_ptr;
    logic [CNT_W-1:0] free_cnt;

    // Per-cycle adjustments to the free count
    logic [CNT_W-1:0] alloc_dec;
    logic [CNT_W-1:0] free_inc;

    always_comb
    begin
        alloc_dec = alloc_en ? CNT_W'(alloc_cnt) : '0;
        free_inc  = free_en ? CNT_W'(1) : '0;
    end

    // ========================================
    // Pointer and free count
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            free_cnt  <= CNT_W'(N_ENTRIES);
        end
        else
        begin
            // The pointer wraps naturally since N_ENTRIES is a power of two
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + IDX_W'(alloc_cnt);
            end

            // Allocation and release may land in the same cycle
            free_cnt <= free_cnt - alloc_dec + free_inc;
        end
    end

    // The base index goes out in the same cycle as the request
    assign alloc_idx = alloc_ptr;

    // Compared as int so the threshold is never truncated to CNT_W bits
    assign not_full = (int'(free_cnt) >= MIN_FREE);

endmodule

`default_nettype wire

//--- hw/rob_rd_pkg.sv
`default_nettype none

package rob_rd_pkg;

    // ========================================
    // Field widths
    // ========================================

    // Opaque tag that the accelerator attaches to every read request
    localparam int MDATA_W = 16;

    // One line of data, narrowed to a single 64-bit word
    localparam int DATA_W = 64;

    // Line address on the request channel
    localparam int ADDR_W = 32;

    // Width of both the beat number and the length field (beats minus one)
    localparam int CL_NUM_W = 2;

    // Largest multi-line request, in lines
    localparam int MAX_BEATS = 4;

    // ========================================
    // Response types
    // ========================================

    // Only RSP_RDLINE is sorted by the ROB
    // The other two share the response channel and pass straight through
    typedef enum logic [1:0] {
        RSP_RDLINE = 2'd0,
        RSP_WRLINE = 2'd1,
        RSP_OTHER  = 2'd2
    } t_rsp_type;

    // ========================================
    // Channel structs
    // ========================================

    // Read request header as issued by the accelerator
    // On the host side mdata holds the ROB base index instead of the user tag
    typedef struct packed {
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        logic [CL_NUM_W-1:0] cl_len;
        logic [MDATA_W-1:0]  mdata;
    } t_rd_req;

    // Response channel beat, shared by read and non-read responses
    // For host read responses mdata is the ROB base index and cl_num the beat
    typedef struct packed {
        logic                valid;
        t_rsp_type           rsp_type;
        logic [MDATA_W-1:0]  mdata;
        logic [CL_NUM_W-1:0] cl_num;
        logic                error;
        logic [DATA_W-1:0]   data;
    } t_c0_rsp;

endpackage

`default_nettype wire
